/* dodge_game_pkg.sv */
// Game geometry and constants; debounce and scroll periods are short for simulation only
`default_nettype none

package dodge_game_pkg;

	//##########################################################
	// Matrix geometry
	//##########################################################

	// Columns in one player lane
	localparam int LANE_WIDTH = 4;
	// Matrix rows, one MAX7219 digit each
	localparam int ROWS = 8;

	// One lane row or one marker position
	typedef logic [LANE_WIDTH-1:0] lane_bits_t;
	// Lane 0 sits in the high nibble of a matrix row
	typedef logic [2*LANE_WIDTH-1:0] row_t;
	// Index 0 is the bottom row of the lane
	typedef lane_bits_t [ROWS-1:0] lane_rows_t;
	// All composed matrix rows
	typedef row_t [ROWS-1:0] frame_t;

	//##########################################################
	// Game constants
	//##########################################################

	// Marker position after every start
	localparam lane_bits_t MARKER_START = 4'b0010;
	// Stable cycles before a button level is accepted
	localparam int DEBOUNCE_CYCLES = 16;
	// Cycles between scroll steps while running
	localparam int SCROLL_PERIOD = 4096;

	// Obstacle generator state after reset and start
	localparam row_t LFSR_SEED = 8'hA5;
	// Taps 7 5 4 3 for x^8+x^6+x^5+x^4+1
	// Register shifts left and the tap parity enters bit 0
	localparam row_t LFSR_TAPS = 8'b1011_1000;

endpackage

`default_nettype wire

/* max7219_pkg.sv */
// MAX7219 register map and serial timing; SPI_HALF_PERIOD is far below a real board's minimum
`default_nettype none

package max7219_pkg;

	// Address in the high byte, data in the low byte
	typedef logic [15:0] word_t;

	// Digit registers 1 to 8 start here
	localparam logic [7:0] REG_DIGIT0 = 8'h01;

	// Control registers
	localparam logic [7:0] REG_DECODE     = 8'h09;
	localparam logic [7:0] REG_INTENSITY  = 8'h0A;
	localparam logic [7:0] REG_SCAN_LIMIT = 8'h0B;
	localparam logic [7:0] REG_SHUTDOWN   = 8'h0C;
	localparam logic [7:0] REG_TEST       = 8'h0F;

	// Brightness level for the intensity register
	localparam logic [3:0] INTENSITY_LEVEL = 4'hA;

	// clock_50 cycles per half period of the serial clock
	localparam int SPI_HALF_PERIOD = 2;

	// Words sent once before the first refresh pass
	localparam int INIT_WORDS = 5;

endpackage

`default_nettype wire

/* matrix_word_if.sv */
// Carries no clock; both ends must run on the same clock and hold valid until ready
`timescale 1ns/1ns
`default_nettype none

interface matrix_word_if;

	// Source holds valid and word until the accepting cycle
	logic valid;
	// Sink is free to take the next word
	logic ready;
	// Register address and data
	max7219_pkg::word_t word;
	// Final digit of a refresh pass
	logic last_row;

	// Frame scanner side
	modport source (
		output valid,
		output word,
		output last_row,
		input  ready
	);

	// Serial driver side
	modport sink (
		input  valid,
		input  word,
		input  last_row,
		output ready
	);

endinterface

`default_nettype wire

/* button_debounce.sv */
// Active-low pin; one press pulse per debounced falling edge, about DEBOUNCE_CYCLES+2 cycles late
`timescale 1ns/1ns
`default_nettype none

module button_debounce (
	input  logic clock_50,
	input  logic rst,
	input  logic button_n,
	output logic press
);

	localparam int CNT_W = $clog2(dodge_game_pkg::DEBOUNCE_CYCLES + 1);

	// Two-flop synchroniser, released level is high
	logic sync_1;
	logic sync_2;
	// Debounced level
	logic level;
	// Cycles the pin has differed from level
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			sync_1 <= 1'b1;
			sync_2 <= 1'b1;
		end else begin
			sync_1 <= button_n;
			sync_2 <= sync_1;
		end
	end

	//##########################################################
	// Stability counter and edge pulse
	//##########################################################

	always_ff @(posedge clock_50) begin
		if (rst) begin
			level      <= 1'b1;
			stable_cnt <= '0;
			press      <= 1'b0;
		end else begin
			press <= 1'b0;
			if (sync_2 == level) begin
				// A bounce back restarts the count
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(dodge_game_pkg::DEBOUNCE_CYCLES)) begin
				level      <= sync_2;
				stable_cnt <= '0;
				// Only a new low level is a press
				press      <= ~sync_2;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// Each debounced press lasts exactly one cycle
	assert property (@(posedge clock_50) disable iff (rst) press |=> !press);

endmodule

`default_nettype wire

/* game_control.sv */
// Never returns to idle; a start in mid-game restarts the timer and reseeds the LFSR
`timescale 1ns/1ns
`default_nettype none

module game_control (
	input  logic clock_50,
	input  logic rst,
	input  logic start_press,
	output logic running,
	output logic restart,
	output logic tick,
	output dodge_game_pkg::row_t next_row
);

	localparam int TIMER_W = $clog2(dodge_game_pkg::SCROLL_PERIOD);

	// Scroll timer
	logic [TIMER_W-1:0] timer;
	// Obstacle generator
	dodge_game_pkg::row_t lfsr;

	// Idle until the first start, restart one cycle after every start
	always_ff @(posedge clock_50) begin
		if (rst) begin
			running <= 1'b0;
			restart <= 1'b0;
		end else begin
			restart <= start_press;
			if (start_press) begin
				running <= 1'b1;
			end
		end
	end

	//##########################################################
	// Scroll timer
	//##########################################################

	always_ff @(posedge clock_50) begin
		if (rst) begin
			timer <= '0;
			tick  <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (restart) begin
				timer <= '0;
			end else if (running) begin
				if (timer == TIMER_W'(dodge_game_pkg::SCROLL_PERIOD - 1)) begin
					timer <= '0;
					tick  <= 1'b1;
				end else begin
					timer <= timer + 1'b1;
				end
			end
		end
	end

	// Steps on each tick; the lanes take the value before the step
	always_ff @(posedge clock_50) begin
		if (rst || restart) begin
			lfsr <= dodge_game_pkg::LFSR_SEED;
		end else if (tick) begin
			lfsr <= {lfsr[6:0], ^(lfsr & dodge_game_pkg::LFSR_TAPS)};
		end
	end

	assign next_row = lfsr;

	// All-zero state would lock up the generator
	assert property (@(posedge clock_50) disable iff (rst) lfsr != '0);

endmodule

`default_nettype wire

/* lane_engine.sv */
// One player lane; restart wins over a tick or a press in the same cycle
`timescale 1ns/1ns
`default_nettype none

module lane_engine (
	input  logic clock_50,
	input  logic rst,
	input  logic restart,
	input  logic tick,
	input  logic left_press,
	input  logic right_press,
	input  dodge_game_pkg::lane_bits_t new_row,
	output dodge_game_pkg::lane_rows_t rows,
	output dodge_game_pkg::lane_bits_t marker
);

	localparam int TOP = dodge_game_pkg::ROWS - 1;

	//##########################################################
	// Obstacle column
	//##########################################################

	always_ff @(posedge clock_50) begin
		if (rst || restart) begin
			rows <= '0;
		end else if (tick) begin
			// Every row drops by one, the new row enters at the top
			rows <= {new_row, rows[TOP:1]};
		end
	end

	//##########################################################
	// Player marker
	//##########################################################

	always_ff @(posedge clock_50) begin
		if (rst || restart) begin
			marker <= dodge_game_pkg::MARKER_START;
		end else if (left_press) begin
			// Left moves toward bit 3
			if (!marker[dodge_game_pkg::LANE_WIDTH-1]) begin
				marker <= marker << 1;
			end
		end else if (right_press) begin
			// Right moves toward bit 0
			if (!marker[0]) begin
				marker <= marker >> 1;
			end
		end
	end

	// Saturating shifts must never lose or duplicate the marker
	assert property (@(posedge clock_50) disable iff (rst) $onehot(marker));

endmodule

`default_nettype wire

/* frame_scanner.sv */
// Five config words once, then endless passes of digits 1 to 8; each pass samples the frame once
`timescale 1ns/1ns
`default_nettype none

module frame_scanner (
	input  logic clock_50,
	input  logic rst,
	input  logic running,
	input  dodge_game_pkg::lane_rows_t lane0_rows,
	input  dodge_game_pkg::lane_rows_t lane1_rows,
	input  dodge_game_pkg::lane_bits_t lane0_marker,
	input  dodge_game_pkg::lane_bits_t lane1_marker,
	matrix_word_if.source words
);

	localparam int IDX_W = $clog2(dodge_game_pkg::ROWS);

	// Live frame and the copy held for one pass
	dodge_game_pkg::frame_t frame_now;
	dodge_game_pkg::frame_t frame_q;
	// Still sending configuration words
	logic in_init;
	// Config word index, then digit index
	logic [IDX_W-1:0] idx;
	max7219_pkg::word_t init_word;
	dodge_game_pkg::row_t row_data;

	//##########################################################
	// Frame composition
	//##########################################################

	always_comb begin
		for (int r = 0; r < dodge_game_pkg::ROWS; r++) begin
			frame_now[r] = {lane0_rows[r], lane1_rows[r]};
		end
		// Markers show on the bottom row only in a game
		if (running) begin
			frame_now[0] = frame_now[0] | {lane0_marker, lane1_marker};
		end
	end

	// Configuration order: decode, intensity, scan limit, shutdown, test
	always_comb begin
		case (idx)
			3'd0: init_word = {max7219_pkg::REG_DECODE, 8'h00};
			3'd1: init_word = {max7219_pkg::REG_INTENSITY, 4'h0, max7219_pkg::INTENSITY_LEVEL};
			3'd2: init_word = {max7219_pkg::REG_SCAN_LIMIT, 8'(dodge_game_pkg::ROWS - 1)};
			3'd3: init_word = {max7219_pkg::REG_SHUTDOWN, 8'h01};
			default: init_word = {max7219_pkg::REG_TEST, 8'h00};
		endcase
	end

	// First digit of a pass reads the live frame
	assign row_data = (idx == '0) ? frame_now[0] : frame_q[idx];

	//##########################################################
	// Word sequencer
	//##########################################################

	always_ff @(posedge clock_50) begin
		if (rst) begin
			words.valid <= 1'b0;
			in_init     <= 1'b1;
			idx         <= '0;
		end else if (!words.valid) begin
			words.valid <= 1'b1;
		end else if (words.ready) begin
			words.valid <= 1'b0;
			if (in_init && idx == IDX_W'(max7219_pkg::INIT_WORDS - 1)) begin
				in_init <= 1'b0;
				idx     <= '0;
			end else begin
				// Digit index wraps after digit 8
				idx <= idx + 1'b1;
			end
		end
	end

	// Payload loads in the cycle valid rises
	always_ff @(posedge clock_50) begin
		if (!words.valid) begin
			words.last_row <= !in_init && idx == IDX_W'(dodge_game_pkg::ROWS - 1);
			if (in_init) begin
				words.word <= init_word;
			end else begin
				words.word <= {max7219_pkg::REG_DIGIT0 + 8'(idx), row_data};
				if (idx == '0) begin
					frame_q <= frame_now;
				end
			end
		end
	end

	// Offered word holds until the serializer takes it
	assert property (@(posedge clock_50) disable iff (rst)
		words.valid && !words.ready |=> words.valid && $stable(words.word));

endmodule

`default_nettype wire

/* max7219_serializer.sv */
// MSB first; ncs stays high one serial period after each word and two after a pass
`timescale 1ns/1ns
`default_nettype none

module max7219_serializer (
	input  logic clock_50,
	input  logic rst,
	matrix_word_if.sink words,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	localparam int DIV_W  = $clog2(max7219_pkg::SPI_HALF_PERIOD) + 1;
	localparam int GAP_W  = $clog2(4 * max7219_pkg::SPI_HALF_PERIOD) + 1;
	localparam int WORD_W = $bits(max7219_pkg::word_t);
	localparam int BIT_W  = $clog2(WORD_W);

	typedef enum logic [1:0] {st_idle, st_shift, st_gap} state_t;

	state_t state;
	// Half-period divider
	logic [DIV_W-1:0] div;
	logic half_done;
	// Bits already sent
	logic [BIT_W-1:0] bit_cnt;
	// Cycles of ncs high
	logic [GAP_W-1:0] gap_cnt;
	logic [GAP_W-1:0] gap_end;
	// Word closed a refresh pass
	logic gap_long;
	max7219_pkg::word_t shreg;

	assign half_done   = (div == DIV_W'(max7219_pkg::SPI_HALF_PERIOD - 1));
	assign gap_end     = gap_long ? GAP_W'(4 * max7219_pkg::SPI_HALF_PERIOD - 1)
	                              : GAP_W'(2 * max7219_pkg::SPI_HALF_PERIOD - 1);
	// Bit on the pin changes only on a falling serial edge
	assign max7219_din = shreg[WORD_W-1];

	always_ff @(posedge clock_50) begin
		if (rst) begin
			state       <= st_idle;
			words.ready <= 1'b1;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			shreg       <= '0;
			div         <= '0;
			bit_cnt     <= '0;
			gap_cnt     <= '0;
			gap_long    <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (words.valid && words.ready) begin
						words.ready <= 1'b0;
						shreg       <= words.word;
						gap_long    <= words.last_row;
						max7219_ncs <= 1'b0;
						div         <= '0;
						bit_cnt     <= '0;
						state       <= st_shift;
					end
				end
				st_shift: begin
					if (!half_done) begin
						div <= div + 1'b1;
					end else begin
						div <= '0;
						if (!max7219_clk) begin
							max7219_clk <= 1'b1;
						end else begin
							max7219_clk <= 1'b0;
							if (bit_cnt == BIT_W'(WORD_W - 1)) begin
								// Rising ncs latches the word in the chip
								max7219_ncs <= 1'b1;
								gap_cnt     <= '0;
								state       <= st_gap;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								shreg   <= shreg << 1;
							end
						end
					end
				end
				st_gap: begin
					if (gap_cnt == gap_end) begin
						words.ready <= 1'b1;
						state       <= st_idle;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// A new word is never taken while the chip is selected
	assert property (@(posedge clock_50) disable iff (rst) words.ready |-> max7219_ncs);

endmodule

`default_nettype wire

/* dodge_game_top.sv */
// Buttons are active low with no on-chip pull-ups; rst must be synchronous to clock_50
`timescale 1ns/1ns
`default_nettype none

module dodge_game_top (
	input  logic clock_50,
	input  logic rst,
	input  logic start_n,
	input  logic [1:0] left_n,
	input  logic [1:0] right_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	// Bit 0 start, bits 1..2 left of each player, bits 3..4 right of each player
	logic [4:0] buttons_n;
	logic [4:0] presses;

	logic running;
	logic restart;
	logic tick;
	dodge_game_pkg::row_t next_row;

	dodge_game_pkg::lane_rows_t lane0_rows;
	dodge_game_pkg::lane_rows_t lane1_rows;
	dodge_game_pkg::lane_bits_t lane0_marker;
	dodge_game_pkg::lane_bits_t lane1_marker;

	// Scanner to serializer word stream
	matrix_word_if words ();

	assign buttons_n = {right_n, left_n, start_n};

	//##########################################################
	// Inputs
	//##########################################################

	generate
		for (genvar i = 0; i < 5; i++) begin : g_button
			button_debounce u_debounce (
				.clock_50 (clock_50),
				.rst      (rst),
				.button_n (buttons_n[i]),
				.press    (presses[i])
			);
		end
	endgenerate

	game_control u_game_control (
		.clock_50    (clock_50),
		.rst         (rst),
		.start_press (presses[0]),
		.running     (running),
		.restart     (restart),
		.tick        (tick),
		.next_row    (next_row)
	);

	//##########################################################
	// Lanes
	//##########################################################

	// Player 0 gets the high nibble of each new row
	lane_engine u_lane0 (
		.clock_50    (clock_50),
		.rst         (rst),
		.restart     (restart),
		.tick        (tick),
		.left_press  (presses[1]),
		.right_press (presses[3]),
		.new_row     (next_row[7:4]),
		.rows        (lane0_rows),
		.marker      (lane0_marker)
	);

	lane_engine u_lane1 (
		.clock_50    (clock_50),
		.rst         (rst),
		.restart     (restart),
		.tick        (tick),
		.left_press  (presses[2]),
		.right_press (presses[4]),
		.new_row     (next_row[3:0]),
		.rows        (lane1_rows),
		.marker      (lane1_marker)
	);

	//##########################################################
	// Display path
	//##########################################################

	frame_scanner u_frame_scanner (
		.clock_50     (clock_50),
		.rst          (rst),
		.running      (running),
		.lane0_rows   (lane0_rows),
		.lane1_rows   (lane1_rows),
		.lane0_marker (lane0_marker),
		.lane1_marker (lane1_marker),
		.words        (words.source)
	);

	max7219_serializer u_serializer (
		.clock_50    (clock_50),
		.rst         (rst),
		.words       (words.sink),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

/* tb_dodge_game.sv */
// Checks the DUT only through its serial pins; assumes SCROLL_PERIOD spans several refresh passes
`timescale 1ns/1ns
`default_nettype none

module tb_dodge_game;

	// Button held low, then high, for this many cycles per press
	localparam int HOLD_CYCLES = dodge_game_pkg::DEBOUNCE_CYCLES + 8;
	// Longest wait for one refresh pass
	localparam int PASS_TIMEOUT = 2000;
	// Longest wait for the configuration words
	localparam int INIT_TIMEOUT = 1000;

	// Button index, same order as the top level packs them
	localparam int BTN_START  = 0;
	localparam int BTN_LEFT0  = 1;
	localparam int BTN_RIGHT1 = 4;

	logic clock_50;
	logic rst;
	logic [4:0] btn_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	// Serial decoder
	logic [15:0] shift_word = '0;
	int bit_total = 0;
	int word_count = 0;
	int next_digit = 1;
	int pass_count = 0;
	logic [15:0] init_seen [5];
	dodge_game_pkg::frame_t cap = '0;
	dodge_game_pkg::frame_t last_pass = '0;

	// Reference model of the game
	dodge_game_pkg::frame_t exp_bg;
	dodge_game_pkg::lane_bits_t exp_m0;
	dodge_game_pkg::lane_bits_t exp_m1;
	dodge_game_pkg::row_t model_lfsr;
	int steps = 0;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err0 = 0;
	// Set by the first expired wait, later waits return at once
	bit stalled = 1'b0;

	dodge_game_top DUT (
		.clock_50    (clock_50),
		.rst         (rst),
		.start_n     (btn_n[0]),
		.left_n      (btn_n[2:1]),
		.right_n     (btn_n[4:3]),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	always #10 clock_50 = ~clock_50;

	//##########################################################
	// Serial decoder
	//##########################################################

	// MSB first, taken on each rising serial clock
	always @(posedge max7219_clk) begin
		if (!max7219_ncs) begin
			shift_word = {shift_word[14:0], max7219_din};
			bit_total++;
		end
	end

	// Rising ncs closes one word
	always @(posedge max7219_ncs) begin
		int addr;
		assert (bit_total == 16 || bit_total == 0) else begin
			$display("A serial word ended after %0d bits", bit_total);
			errors++;
		end
		if (bit_total == 16) begin
			addr = int'(shift_word[15:8]);
			if (word_count < 5) begin
				init_seen[word_count] = shift_word;
			end else begin
				// Refresh digits come in order 1 to 8
				assert (addr == next_digit) else begin
					$display("[ERROR] digit address got %h expected %h", addr, next_digit);
					errors++;
				end
				if (addr >= 1 && addr <= 8) begin
					cap[addr-1] = shift_word[7:0];
				end
				if (addr == 8) begin
					last_pass = cap;
					pass_count++;
				end
				next_digit = (addr >= 8) ? 1 : addr + 1;
			end
			word_count++;
		end
		bit_total = 0;
	end

	// Serial clock rests low while the chip is deselected
	assert property (@(posedge clock_50) disable iff (rst) max7219_ncs |-> !max7219_clk)
	else begin
		$display("Serial clock was high while ncs was high");
		errors++;
	end

	// Data must not move while the serial clock is high
	assert property (@(posedge clock_50) disable iff (rst) max7219_clk |-> $stable(max7219_din))
	else begin
		$display("[ERROR] max7219_din changed while max7219_clk high, was %h now %h",
			$past(max7219_din), max7219_din);
		errors++;
	end

	//##########################################################
	// Reference model
	//##########################################################

	// Shift left, taps 7 5 4 3 feed bit 0
	function automatic dodge_game_pkg::row_t lfsr_next(input dodge_game_pkg::row_t v);
		return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
	endfunction

	// Markers of lane 0 and lane 1 land in the bottom row
	function automatic dodge_game_pkg::frame_t with_markers(input dodge_game_pkg::frame_t bg);
		dodge_game_pkg::frame_t f;
		f = bg;
		f[0] = bg[0] | {exp_m0, exp_m1};
		return f;
	endfunction

	task automatic restart_model();
		exp_bg = '0;
		exp_m0 = dodge_game_pkg::MARKER_START;
		exp_m1 = dodge_game_pkg::MARKER_START;
		model_lfsr = dodge_game_pkg::LFSR_SEED;
	endtask

	// A pass either repeats the model or shows exactly one scroll step
	task automatic check_frame(input dodge_game_pkg::frame_t f);
		dodge_game_pkg::frame_t stepped;
		dodge_game_pkg::frame_t same_exp;
		dodge_game_pkg::frame_t step_exp;
		stepped = {model_lfsr, exp_bg[7:1]};
		same_exp = with_markers(exp_bg);
		step_exp = with_markers(stepped);
		if (f != same_exp && f == step_exp) begin
			exp_bg = stepped;
			model_lfsr = lfsr_next(model_lfsr);
			steps++;
		end
		assert (f == same_exp || f == step_exp) else begin
			$display("[ERROR] frame got %h expected %h or %h", f, same_exp, step_exp);
			errors++;
		end
	endtask

	//##########################################################
	// Stimulus and waits
	//##########################################################

	task automatic press_button(input int idx);
		@(posedge clock_50);
		#2;
		btn_n[idx] = 1'b0;
		repeat (HOLD_CYCLES) @(posedge clock_50);
		#2;
		btn_n[idx] = 1'b1;
		repeat (HOLD_CYCLES) @(posedge clock_50);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		errors++;
		stalled = 1'b1;
	endtask

	task automatic next_pass(output dodge_game_pkg::frame_t f);
		int start_count;
		int waited;
		start_count = pass_count;
		waited = 0;
		while (!stalled && pass_count == start_count && waited < PASS_TIMEOUT) begin
			@(posedge clock_50);
			waited++;
		end
		if (!stalled && pass_count == start_count) begin
			report_timeout("no refresh pass finished");
		end
		f = last_pass;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err0) begin
			tests_failed++;
			$display("Test %0d %s: failed, %0d errors", tests_run, name, errors - test_err0);
		end else begin
			$display("Test %0d %s: ok", tests_run, name);
		end
		test_err0 = errors;
	endtask

	//##########################################################
	// Test sequence
	//##########################################################

	initial begin
		dodge_game_pkg::frame_t f;
		logic [15:0] init_exp [5];
		logic [3:0] left_want [3];
		int waited;
		int tries;
		int steps0;
		init_exp = '{16'h0900, 16'h0A0A, 16'h0B07, 16'h0C01, 16'h0F00};
		left_want = '{4'b0100, 4'b1000, 4'b1000};
		clock_50 = 1'b0;
		rst = 1'b1;
		btn_n = '1;
		restart_model();
		repeat (8) @(posedge clock_50);
		#2;
		rst = 1'b0;

		// Idle pins, then the five configuration words
		assert (max7219_ncs && !max7219_clk && !max7219_din && DUT.presses == '0) else begin
			$display("[ERROR] ncs clk din presses got %h %h %h %h expected 1 0 0 00",
				max7219_ncs, max7219_clk, max7219_din, DUT.presses);
			errors++;
		end
		waited = 0;
		while (word_count < 5 && waited < INIT_TIMEOUT) begin
			@(posedge clock_50);
			waited++;
		end
		if (word_count < 5) begin
			report_timeout("configuration words never arrived");
		end else begin
			for (int i = 0; i < 5; i++) begin
				assert (init_seen[i] == init_exp[i]) else begin
					$display("[ERROR] config word %0d got %h expected %h",
						i, init_seen[i], init_exp[i]);
					errors++;
				end
			end
		end
		end_test("configuration sequence");

		// Blank matrix before the first start
		for (int i = 0; i < 3; i++) begin
			next_pass(f);
			assert (f == '0) else begin
				$display("[ERROR] idle frame got %h expected 0", f);
				errors++;
			end
		end
		end_test("idle frame");

		// First pass with markers after start
		press_button(BTN_START);
		restart_model();
		f = '0;
		tries = 0;
		while (f[0] == 8'h00 && tries < 4) begin
			next_pass(f);
			tries++;
		end
		assert (f == {56'h0, 8'h22}) else begin
			$display("[ERROR] frame after start got %h expected %h", f, {56'h0, 8'h22});
			errors++;
		end
		end_test("start shows markers");

		// Saturating marker moves; the first pass after a press may predate it
		for (int i = 0; i < 3; i++) begin
			press_button(BTN_LEFT0);
			if (!exp_m0[3]) begin
				exp_m0 = exp_m0 << 1;
			end
			next_pass(f);
			next_pass(f);
			check_frame(f);
			assert (f[0][7:4] == left_want[i]) else begin
				$display("[ERROR] lane 0 marker got %h expected %h", f[0][7:4], left_want[i]);
				errors++;
			end
		end
		for (int i = 0; i < 3; i++) begin
			press_button(BTN_RIGHT1);
			if (!exp_m1[0]) begin
				exp_m1 = exp_m1 >> 1;
			end
			next_pass(f);
			next_pass(f);
			check_frame(f);
			assert (f[0][3:0] == 4'b0001) else begin
				$display("[ERROR] lane 1 marker got %h expected 1", f[0][3:0]);
				errors++;
			end
		end
		end_test("marker movement");

		// Enough steps for new rows to reach the bottom row
		steps0 = steps;
		tries = 0;
		while (steps - steps0 < 9 && tries < 100) begin
			next_pass(f);
			check_frame(f);
			tries++;
		end
		assert (steps - steps0 >= 9) else begin
			$display("Background made only %0d scroll steps in %0d passes", steps - steps0, tries);
			errors++;
		end
		end_test("scrolling");

		// Start in mid-game clears the lanes and reseeds the rows
		press_button(BTN_START);
		restart_model();
		next_pass(f);
		next_pass(f);
		assert (f == {56'h0, 8'h22}) else begin
			$display("[ERROR] frame after restart got %h expected %h", f, {56'h0, 8'h22});
			errors++;
		end
		steps0 = steps;
		tries = 0;
		while (steps == steps0 && tries < 12) begin
			next_pass(f);
			check_frame(f);
			tries++;
		end
		assert (steps != steps0 && f[7] == dodge_game_pkg::LFSR_SEED) else begin
			$display("[ERROR] top row after restart got %h expected %h",
				f[7], dodge_game_pkg::LFSR_SEED);
			errors++;
		end
		end_test("restart");

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dodge_game.f */
dodge_game_pkg.sv
max7219_pkg.sv
matrix_word_if.sv
button_debounce.sv
game_control.sv
lane_engine.sv
frame_scanner.sv
max7219_serializer.sv
dodge_game_top.sv
tb_dodge_game.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dodge game testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dodge_game \
	-f dodge_game.f \
	-o sim_dodge_game

./obj_dir/sim_dodge_game | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi
